/* include/exu_cfg.svh */
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// Data path width of the core.
`define EXU_XLEN 64

// Default micro-op FIFO depth. Two is the minimum.
`define EXU_FIFO_DEPTH 2

`endif

/* src/exu_pkg.sv */
`include "exu_cfg.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;
  typedef logic [31:0]          inst_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [11:0]          csr_addr_t;

  typedef enum logic [2:0] {
    UOP_ALU,
    UOP_BRANCH,
    UOP_JAL,
    UOP_JALR,
    UOP_CSR,
    UOP_ECALL,
    UOP_MRET,
    UOP_NOP
  } uop_kind_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_LTU} br_cond_e;

  typedef enum logic [1:0] {CSR_RW, CSR_RS, CSR_RC} csr_op_e;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam xlen_t MCAUSE_ECALL_M = 11; // Environment call from M-mode.

endpackage

/* src/uop_if.sv */
`timescale 1ns/1ns

interface uop_if;
  import exu_pkg::*;

  logic      valid;
  logic      ready;
  uop_kind_e kind;
  alu_op_e   alu_op;
  br_cond_e  br_cond;
  csr_op_e   csr_op;
  reg_idx_t  rd;
  logic      rd_wen;
  xlen_t     pc;
  xlen_t     src1;
  xlen_t     src2;
  xlen_t     imm;
  csr_addr_t csr_addr;

  modport producer (
    output valid, kind, alu_op, br_cond, csr_op, rd, rd_wen, pc, src1, src2, imm, csr_addr,
    input  ready
  );

  modport consumer (
    input  valid, kind, alu_op, br_cond, csr_op, rd, rd_wen, pc, src1, src2, imm, csr_addr,
    output ready
  );

endinterface

/* src/op_decoder.sv */
`timescale 1ns/1ns

module op_decoder (
  input  logic           clk,
  input  logic           rst,
  input  logic           inst_valid_i,
  output logic           inst_ready_o,
  input  exu_pkg::inst_t inst_i,
  input  exu_pkg::xlen_t pc_i,
  input  exu_pkg::xlen_t rs1_val_i,
  input  exu_pkg::xlen_t rs2_val_i,
  uop_if.producer        uop_o
);
  import exu_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  xlen_t      imm_i;
  xlen_t      imm_b;
  xlen_t      imm_j;
  uop_kind_e  kind;
  alu_op_e    alu_op;
  br_cond_e   br_cond;
  csr_op_e    csr_op;
  logic       accept;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd     = inst_i[11:7];

  assign imm_i = xlen_t'($signed(inst_i[31:20]));
  assign imm_b = xlen_t'($signed({inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0}));
  assign imm_j = xlen_t'($signed({inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0}));

  always_comb begin
    kind    = UOP_NOP;
    alu_op  = ALU_ADD;
    br_cond = BR_EQ;
    csr_op  = CSR_RW;
    case (opcode)
      OPC_OP: begin
        alu_op = alu_sel(funct3, funct7[5]);
        if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          kind = UOP_ALU;
        end
      end
      OPC_OP_IMM: begin
        alu_op = alu_sel(funct3, funct3 == 3'b101 && inst_i[30]);
        // RV64 shifts carry a 6-bit shamt.
        if (funct3 == 3'b001) begin
          kind = (inst_i[31:26] == 6'b000000) ? UOP_ALU : UOP_NOP;
        end else if (funct3 == 3'b101) begin
          kind = (inst_i[31:26] == 6'b000000 || inst_i[31:26] == 6'b010000) ? UOP_ALU : UOP_NOP;
        end else begin
          kind = UOP_ALU;
        end
      end
      OPC_BRANCH: begin
        kind = UOP_BRANCH;
        case (funct3)
          3'b000:  br_cond = BR_EQ;
          3'b001:  br_cond = BR_NE;
          3'b100:  br_cond = BR_LT;
          3'b110:  br_cond = BR_LTU;
          default: kind = UOP_NOP;
        endcase
      end
      OPC_JAL:  kind = UOP_JAL;
      OPC_JALR: kind = (funct3 == 3'b000) ? UOP_JALR : UOP_NOP;
      OPC_SYSTEM: begin
        case (funct3)
          3'b001: begin kind = UOP_CSR; csr_op = CSR_RW; end
          3'b010: begin kind = UOP_CSR; csr_op = CSR_RS; end
          3'b011: begin kind = UOP_CSR; csr_op = CSR_RC; end
          3'b000: begin
            if (inst_i == 32'h0000_0073) kind = UOP_ECALL;
            else if (inst_i == 32'h3020_0073) kind = UOP_MRET;
          end
          default: kind = UOP_NOP;
        endcase
      end
      default: kind = UOP_NOP;
    endcase
  end

  assign inst_ready_o = !uop_o.valid || uop_o.ready; // Slot empty or draining.
  assign accept = inst_valid_i && inst_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      uop_o.valid <= 1'b0;
    end else if (accept) begin
      uop_o.valid <= 1'b1;
    end else if (uop_o.ready) begin
      uop_o.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      uop_o.kind     <= kind;
      uop_o.alu_op   <= alu_op;
      uop_o.br_cond  <= br_cond;
      uop_o.csr_op   <= csr_op;
      uop_o.rd       <= rd;
      uop_o.rd_wen   <= (kind inside {UOP_ALU, UOP_JAL, UOP_JALR, UOP_CSR}) && (rd != '0);
      uop_o.pc       <= pc_i;
      uop_o.src1     <= rs1_val_i;
      uop_o.src2     <= (opcode == OPC_OP_IMM) ? imm_i : rs2_val_i;
      uop_o.imm      <= (opcode == OPC_JAL) ? imm_j : (opcode == OPC_BRANCH) ? imm_b : imm_i;
      uop_o.csr_addr <= inst_i[31:20];
    end
  end

endmodule

/* src/uop_fifo.sv */
`include "exu_cfg.svh"
`timescale 1ns/1ns

module uop_fifo #(
  parameter int DEPTH = `EXU_FIFO_DEPTH
) (
  input logic     clk,
  input logic     rst,
  uop_if.consumer in_i,
  uop_if.producer out_o
);
  import exu_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  uop_kind_e kind_q     [DEPTH];
  alu_op_e   alu_op_q   [DEPTH];
  br_cond_e  br_cond_q  [DEPTH];
  csr_op_e   csr_op_q   [DEPTH];
  reg_idx_t  rd_q       [DEPTH];
  logic      rd_wen_q   [DEPTH];
  xlen_t     pc_q       [DEPTH];
  xlen_t     src1_q     [DEPTH];
  xlen_t     src2_q     [DEPTH];
  xlen_t     imm_q      [DEPTH];
  csr_addr_t csr_addr_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wraps for depths that are not a power of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_i.ready  = (count != CNT_W'(DEPTH)); // Low only when full.
  assign out_o.valid = (count != '0);
  assign push = in_i.valid && in_i.ready;
  assign pop  = out_o.valid && out_o.ready;

  assign out_o.kind     = kind_q[rd_ptr];
  assign out_o.alu_op   = alu_op_q[rd_ptr];
  assign out_o.br_cond  = br_cond_q[rd_ptr];
  assign out_o.csr_op   = csr_op_q[rd_ptr];
  assign out_o.rd       = rd_q[rd_ptr];
  assign out_o.rd_wen   = rd_wen_q[rd_ptr];
  assign out_o.pc       = pc_q[rd_ptr];
  assign out_o.src1     = src1_q[rd_ptr];
  assign out_o.src2     = src2_q[rd_ptr];
  assign out_o.imm      = imm_q[rd_ptr];
  assign out_o.csr_addr = csr_addr_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      kind_q[wr_ptr]     <= in_i.kind;
      alu_op_q[wr_ptr]   <= in_i.alu_op;
      br_cond_q[wr_ptr]  <= in_i.br_cond;
      csr_op_q[wr_ptr]   <= in_i.csr_op;
      rd_q[wr_ptr]       <= in_i.rd;
      rd_wen_q[wr_ptr]   <= in_i.rd_wen;
      pc_q[wr_ptr]       <= in_i.pc;
      src1_q[wr_ptr]     <= in_i.src1;
      src2_q[wr_ptr]     <= in_i.src2;
      imm_q[wr_ptr]      <= in_i.imm;
      csr_addr_q[wr_ptr] <= in_i.csr_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/exu_alu.sv */
`timescale 1ns/1ns

module exu_alu (
  input  exu_pkg::alu_op_e  alu_op_i,
  input  exu_pkg::br_cond_e br_cond_i,
  input  exu_pkg::xlen_t    a_i,
  input  exu_pkg::xlen_t    b_i,
  output exu_pkg::xlen_t    result_o,
  output logic              taken_o
);
  import exu_pkg::*;

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[5:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);
      ALU_SLT:  result_o = xlen_t'(lt_s);
      ALU_SLTU: result_o = xlen_t'(lt_u);
      default:  result_o = '0;
    endcase
  end

  always_comb begin
    case (br_cond_i)
      BR_EQ:   taken_o = (a_i == b_i);
      BR_NE:   taken_o = (a_i != b_i);
      BR_LT:   taken_o = lt_s;
      default: taken_o = lt_u;
    endcase
  end

endmodule

/* src/csr_file.sv */
`timescale 1ns/1ns

module csr_file (
  input  logic               clk,
  input  logic               rst,
  input  exu_pkg::csr_addr_t raddr_i,
  output exu_pkg::xlen_t     rdata_o,
  input  logic               wen_i,
  input  exu_pkg::csr_addr_t waddr_i,
  input  exu_pkg::xlen_t     wdata_i,
  input  logic               ecall_i,
  input  logic               mret_i,
  input  exu_pkg::xlen_t     epc_i,
  output exu_pkg::xlen_t     mepc_o,
  output exu_pkg::xlen_t     mtvec_o
);
  import exu_pkg::*;

  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;

  xlen_t mstatus;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t mtvec;

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      CSR_MTVEC:   rdata_o = mtvec;
      default:     rdata_o = '0; // Unimplemented reads as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mtvec   <= '0;
    end else if (ecall_i) begin
      mepc              <= epc_i;
      mcause            <= MCAUSE_ECALL_M;
      mstatus[MPIE_BIT] <= mstatus[MIE_BIT];
      mstatus[MIE_BIT]  <= 1'b0;
    end else if (mret_i) begin
      mstatus[MIE_BIT]  <= mstatus[MPIE_BIT];
      mstatus[MPIE_BIT] <= 1'b1;
    end else if (wen_i) begin
      case (waddr_i)
        CSR_MSTATUS: mstatus <= wdata_i;
        CSR_MEPC:    mepc    <= wdata_i;
        CSR_MCAUSE:  mcause  <= wdata_i;
        CSR_MTVEC:   mtvec   <= wdata_i;
        default:     ;
      endcase
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
  input  logic              clk,
  input  logic              rst,
  uop_if.consumer           uop_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output exu_pkg::reg_idx_t res_rd_o,
  output logic              res_wen_o,
  output exu_pkg::xlen_t    res_data_o,
  output logic              res_redirect_o,
  output exu_pkg::xlen_t    res_npc_o
);
  import exu_pkg::*;

  xlen_t alu_res;
  logic  taken;
  xlen_t csr_rdata;
  xlen_t csr_wdata;
  xlen_t mepc;
  xlen_t mtvec;
  xlen_t pc_plus4;
  xlen_t pc_tgt;
  xlen_t jalr_tgt;
  logic  accept;
  xlen_t data_d;
  xlen_t npc_d;
  logic  redirect_d;
  logic  wen_d;

  exu_alu u_alu (
    .alu_op_i  (uop_i.alu_op),
    .br_cond_i (uop_i.br_cond),
    .a_i       (uop_i.src1),
    .b_i       (uop_i.src2),
    .result_o  (alu_res),
    .taken_o   (taken)
  );

  // Commits on the same edge that loads the result slot.
  csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .raddr_i (uop_i.csr_addr),
    .rdata_o (csr_rdata),
    .wen_i   (accept && uop_i.kind == UOP_CSR),
    .waddr_i (uop_i.csr_addr),
    .wdata_i (csr_wdata),
    .ecall_i (accept && uop_i.kind == UOP_ECALL),
    .mret_i  (accept && uop_i.kind == UOP_MRET),
    .epc_i   (uop_i.pc),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  assign uop_i.ready = !res_valid_o || res_ready_i;
  assign accept      = uop_i.valid && uop_i.ready;

  assign pc_plus4 = uop_i.pc + xlen_t'(4);
  assign pc_tgt   = uop_i.pc + uop_i.imm;
  assign jalr_tgt = (uop_i.src1 + uop_i.imm) & ~xlen_t'(1);

  always_comb begin
    case (uop_i.csr_op)
      CSR_RS:  csr_wdata = csr_rdata | uop_i.src1;
      CSR_RC:  csr_wdata = csr_rdata & ~uop_i.src1;
      default: csr_wdata = uop_i.src1;
    endcase
  end

  always_comb begin
    data_d     = '0;
    npc_d      = '0;
    redirect_d = 1'b0;
    wen_d      = uop_i.rd_wen;
    case (uop_i.kind)
      UOP_ALU: data_d = alu_res;
      UOP_JAL: begin
        data_d     = pc_plus4;
        redirect_d = 1'b1;
        npc_d      = pc_tgt;
      end
      UOP_JALR: begin
        data_d     = pc_plus4;
        redirect_d = 1'b1;
        npc_d      = jalr_tgt;
      end
      UOP_BRANCH: begin
        redirect_d = taken;
        npc_d      = taken ? pc_tgt : '0;
      end
      UOP_CSR: data_d = csr_rdata; // Old value.
      UOP_ECALL: begin
        redirect_d = 1'b1;
        npc_d      = mtvec; // Value before the trap commits.
      end
      UOP_MRET: begin
        redirect_d = 1'b1;
        npc_d      = mepc;
      end
      default: wen_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_o <= 1'b0;
    end else if (accept) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_rd_o       <= uop_i.rd;
      res_wen_o      <= wen_d;
      res_data_o     <= data_d;
      res_redirect_o <= redirect_d;
      res_npc_o      <= npc_d;
    end
  end

endmodule

/* src/exu_top.sv */
`timescale 1ns/1ns

module exu_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  input  exu_pkg::inst_t    inst_i,
  input  exu_pkg::xlen_t    pc_i,
  input  exu_pkg::xlen_t    rs1_val_i,
  input  exu_pkg::xlen_t    rs2_val_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output exu_pkg::reg_idx_t res_rd_o,
  output logic              res_wen_o,
  output exu_pkg::xlen_t    res_data_o,
  output logic              res_redirect_o,
  output exu_pkg::xlen_t    res_npc_o
);

  uop_if dec_to_fifo ();
  uop_if fifo_to_exu ();

  op_decoder u_decoder (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_val_i    (rs1_val_i),
    .rs2_val_i    (rs2_val_i),
    .uop_o        (dec_to_fifo)
  );

  uop_fifo u_fifo (
    .clk   (clk),
    .rst   (rst),
    .in_i  (dec_to_fifo),
    .out_o (fifo_to_exu)
  );

  exec_unit u_exec (
    .clk            (clk),
    .rst            (rst),
    .uop_i          (fifo_to_exu),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_rd_o       (res_rd_o),
    .res_wen_o      (res_wen_o),
    .res_data_o     (res_data_o),
    .res_redirect_o (res_redirect_o),
    .res_npc_o      (res_npc_o)
  );

endmodule

/* sim/tb_exu_top.sv */
`timescale 1ns/1ns

module tb_exu_top;
  import exu_pkg::*;

  localparam int N_INST     = 2000;
  localparam int MAX_CYCLES = 8 * N_INST + 100;

  localparam int K_R     = 0;
  localparam int K_I     = 1;
  localparam int K_BR    = 2;
  localparam int K_JAL   = 3;
  localparam int K_JALR  = 4;
  localparam int K_CSR   = 5;
  localparam int K_ECALL = 6;
  localparam int K_MRET  = 7;
  localparam int K_BAD   = 8;

  typedef struct packed {
    reg_idx_t rd;
    logic     wen;
    xlen_t    data;
    logic     redirect;
    xlen_t    npc;
  } result_t;

  logic     clk = 1'b0;
  logic     rst;
  logic     inst_valid_i;
  logic     inst_ready_o;
  inst_t    inst_i;
  xlen_t    pc_i;
  xlen_t    rs1_val_i;
  xlen_t    rs2_val_i;
  logic     res_valid_o;
  logic     res_ready_i;
  reg_idx_t res_rd_o;
  logic     res_wen_o;
  xlen_t    res_data_o;
  logic     res_redirect_o;
  xlen_t    res_npc_o;

  result_t exp_q[$];
  xlen_t   m_mstatus;
  xlen_t   m_mepc;
  xlen_t   m_mcause;
  xlen_t   m_mtvec;
  xlen_t   cur_pc;
  int      cycle = 0;
  int      sent = 0;
  logic    bp_en;

  exu_top exu_top_i (.*);

  always #5 clk = ~clk;

  task automatic stop_with_errors();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on the first error");
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > MAX_CYCLES) begin
      $display("Timeout: the run took more than %0d cycles.", MAX_CYCLES);
      stop_with_errors();
    end
  end

  function automatic xlen_t alu_ref(input alu_op_e op, input xlen_t a, input xlen_t b);
    logic [5:0] sh;
    sh = b[5:0]; // RV64 shift amount.
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return xlen_t'($signed(a) >>> sh);
      ALU_SLT: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      default: return (a < b) ? 64'd1 : 64'd0;
    endcase
  endfunction

  function automatic logic cond_ref(input br_cond_e c, input xlen_t a, input xlen_t b);
    case (c)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      default: return a < b;
    endcase
  endfunction

  function automatic logic [2:0] alu_funct3(input alu_op_e op);
    case (op)
      ALU_ADD, ALU_SUB: return 3'b000;
      ALU_SLL:          return 3'b001;
      ALU_SLT:          return 3'b010;
      ALU_SLTU:         return 3'b011;
      ALU_XOR:          return 3'b100;
      ALU_SRL, ALU_SRA: return 3'b101;
      ALU_OR:           return 3'b110;
      default:          return 3'b111;
    endcase
  endfunction

  function automatic xlen_t csr_read_ref(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS: return m_mstatus;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      CSR_MTVEC:   return m_mtvec;
      default:     return '0;
    endcase
  endfunction

  task automatic csr_write_ref(input csr_addr_t addr, input xlen_t val);
    case (addr)
      CSR_MSTATUS: m_mstatus = val;
      CSR_MEPC:    m_mepc = val;
      CSR_MCAUSE:  m_mcause = val;
      CSR_MTVEC:   m_mtvec = val;
      default:     ;
    endcase
  endtask

  task automatic check_data(input reg_idx_t rd, input logic wen, input xlen_t data);
    if (res_wen_o !== wen) begin
      $display("FAIL time=%0t res_wen_o expected=%b actual=%b", $time, wen, res_wen_o);
      stop_with_errors();
    end
    if (wen && res_rd_o !== rd) begin
      $display("FAIL time=%0t res_rd_o expected=%0d actual=%0d", $time, rd, res_rd_o);
      stop_with_errors();
    end
    if (wen && res_data_o !== data) begin
      $display("FAIL time=%0t res_data_o expected=%h actual=%h", $time, data, res_data_o);
      stop_with_errors();
    end
  endtask

  task automatic check_redirect(input logic redirect, input xlen_t npc);
    if (res_redirect_o !== redirect) begin
      $display("FAIL time=%0t res_redirect_o expected=%b actual=%b", $time, redirect,
               res_redirect_o);
      stop_with_errors();
    end
    if (res_npc_o !== npc) begin
      $display("FAIL time=%0t res_npc_o expected=%h actual=%h", $time, npc, res_npc_o);
      stop_with_errors();
    end
  endtask

  // Encodes one instruction, predicts its result and holds it until accepted.
  task automatic send(input int kind, input int sel, input xlen_t imm, input reg_idx_t rd,
                      input csr_addr_t caddr, input xlen_t a, input xlen_t b);
    inst_t      inst;
    result_t    want;
    xlen_t      old;
    xlen_t      nv;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       taken;
    want    = '0;
    want.rd = rd;
    case (kind)
      K_R: begin
        f3 = alu_funct3(alu_op_e'(sel));
        f7 = (sel == ALU_SUB || sel == ALU_SRA) ? 7'h20 : 7'h00;
        inst = {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
        want.wen  = (rd != 5'd0);
        want.data = alu_ref(alu_op_e'(sel), a, b);
      end
      K_I: begin
        f3 = alu_funct3(alu_op_e'(sel));
        f7 = (sel == ALU_SRA) ? {6'b010000, imm[5]} : imm[11:5];
        inst = {f7, imm[4:0], 5'd1, f3, rd, 7'b0010011};
        want.wen  = (rd != 5'd0);
        want.data = alu_ref(alu_op_e'(sel), a, imm);
      end
      K_BR: begin
        case (br_cond_e'(sel))
          BR_EQ:   f3 = 3'b000;
          BR_NE:   f3 = 3'b001;
          BR_LT:   f3 = 3'b100;
          default: f3 = 3'b110;
        endcase
        inst = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
        taken = cond_ref(br_cond_e'(sel), a, b);
        want.redirect = taken;
        want.npc      = taken ? cur_pc + imm : '0;
      end
      K_JAL: begin
        inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
        want.wen      = (rd != 5'd0);
        want.data     = cur_pc + 64'd4;
        want.redirect = 1'b1;
        want.npc      = cur_pc + imm;
      end
      K_JALR: begin
        inst = {imm[11:0], 5'd1, 3'b000, rd, 7'b1100111};
        want.wen      = (rd != 5'd0);
        want.data     = cur_pc + 64'd4;
        want.redirect = 1'b1;
        want.npc      = (a + imm) & ~64'd1;
      end
      K_CSR: begin
        f3 = 3'(sel + 1);
        inst = {caddr, 5'd1, f3, rd, 7'b1110011};
        old = csr_read_ref(caddr);
        case (csr_op_e'(sel))
          CSR_RS:  nv = old | a;
          CSR_RC:  nv = old & ~a;
          default: nv = a;
        endcase
        csr_write_ref(caddr, nv);
        want.wen  = (rd != 5'd0);
        want.data = old;
      end
      K_ECALL: begin
        inst = 32'h0000_0073;
        want.redirect = 1'b1;
        want.npc      = m_mtvec;
        m_mepc        = cur_pc;
        m_mcause      = 64'd11;
        m_mstatus[7]  = m_mstatus[3]; // MPIE takes MIE.
        m_mstatus[3]  = 1'b0;
      end
      K_MRET: begin
        inst = 32'h3020_0073;
        want.redirect = 1'b1;
        want.npc      = m_mepc;
        m_mstatus[3]  = m_mstatus[7];
        m_mstatus[7]  = 1'b1;
      end
      default: inst = {imm[24:0], 7'b0000011}; // Load opcode is unsupported.
    endcase
    inst_valid_i = 1'b1;
    inst_i       = inst;
    pc_i         = cur_pc;
    rs1_val_i    = a;
    rs2_val_i    = b;
    while (!inst_ready_o) @(negedge clk);
    exp_q.push_back(want);
    sent++;
    cur_pc = cur_pc + 64'd4;
    @(negedge clk);
  endtask

  task automatic send_random();
    int        pick;
    alu_op_e   op;
    xlen_t     a;
    xlen_t     b;
    xlen_t     imm;
    reg_idx_t  rd;
    csr_addr_t caddr;
    pick = $urandom_range(99);
    a    = {$urandom, $urandom};
    b    = {$urandom, $urandom};
    rd   = reg_idx_t'($urandom_range(31));
    imm  = xlen_t'($signed(12'($urandom)));
    op   = alu_op_e'($urandom_range(9));
    if (pick < 40) begin
      send(K_R, op, '0, rd, '0, a, b);
    end else if (pick < 60) begin
      if (op == ALU_SUB) op = ALU_ADD;
      if (op inside {ALU_SLL, ALU_SRL, ALU_SRA}) imm = xlen_t'(6'($urandom));
      send(K_I, op, imm, rd, '0, a, b);
    end else if (pick < 70) begin
      if ($urandom_range(1) == 0) b = a; // Exercise the equal case.
      imm = xlen_t'($signed({12'($urandom), 1'b0}));
      send(K_BR, $urandom_range(3), imm, rd, '0, a, b);
    end else if (pick < 74) begin
      imm = xlen_t'($signed({20'($urandom), 1'b0}));
      send(K_JAL, 0, imm, rd, '0, a, b);
    end else if (pick < 78) begin
      send(K_JALR, 0, imm, rd, '0, a, b);
    end else if (pick < 92) begin
      case ($urandom_range(4))
        0:       caddr = CSR_MSTATUS;
        1:       caddr = CSR_MEPC;
        2:       caddr = CSR_MCAUSE;
        3:       caddr = CSR_MTVEC;
        default: caddr = 12'h7c0 + 12'($urandom_range(15)); // Unknown address.
      endcase
      send(K_CSR, $urandom_range(2), '0, rd, caddr, a, b);
    end else if (pick < 95) begin
      send(K_ECALL, 0, '0, 5'd0, '0, a, b);
    end else if (pick < 97) begin
      send(K_MRET, 0, '0, 5'd0, '0, a, b);
    end else begin
      send(K_BAD, 0, {$urandom, $urandom}, rd, '0, a, b);
    end
  endtask

  // Results seen here transfer on the next rising edge.
  always @(negedge clk) begin
    result_t want;
    res_ready_i = (bp_en && $urandom_range(99) < 30) ? 1'b0 : 1'b1;
    if (!rst && res_valid_o && res_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A result arrived at %0t with no instruction left to match it.", $time);
        stop_with_errors();
      end else begin
        want = exp_q.pop_front();
        check_data(want.rd, want.wen, want.data);
        check_redirect(want.redirect, want.npc);
      end
    end
  end

  initial begin
    int n;
    int start;
    void'($urandom(32'ha9fedebc));
    rst          = 1'b1;
    bp_en        = 1'b0;
    res_ready_i  = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    rs1_val_i    = '0;
    rs2_val_i    = '0;
    m_mstatus    = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtvec      = '0;
    cur_pc       = {$urandom, $urandom} & ~64'd3;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    if (res_valid_o !== 1'b0) begin
      $display("FAIL time=%0t res_valid_o expected=0 actual=%b", $time, res_valid_o);
      stop_with_errors();
    end
    if (inst_ready_o !== 1'b1) begin
      $display("FAIL time=%0t inst_ready_o expected=1 actual=%b", $time, inst_ready_o);
      stop_with_errors();
    end

    // Single instruction through empty stages.
    start = cycle;
    send(K_R, ALU_ADD, '0, 5'd3, '0, 64'd5, 64'd7);
    inst_valid_i = 1'b0;
    while (!res_valid_o) @(negedge clk);
    if (cycle - start != 3) begin
      $display("FAIL time=%0t res_valid_o latency expected=3 actual=%0d", $time, cycle - start);
      stop_with_errors();
    end

    bp_en = 1'b1;
    send(K_CSR, CSR_RW, '0, 5'd1, CSR_MTVEC, {$urandom, $urandom} & ~64'd3, '0);
    send(K_CSR, CSR_RS, '0, 5'd2, CSR_MSTATUS, 64'h8, '0); // Set MIE.
    send(K_ECALL, 0, '0, 5'd0, '0, '0, '0);
    send(K_CSR, CSR_RS, '0, 5'd3, CSR_MEPC, '0, '0);
    send(K_CSR, CSR_RS, '0, 5'd4, CSR_MCAUSE, '0, '0);
    send(K_MRET, 0, '0, 5'd0, '0, '0, '0);
    send(K_CSR, CSR_RS, '0, 5'd5, CSR_MSTATUS, '0, '0);
    send(K_CSR, CSR_RC, '0, 5'd6, CSR_MSTATUS, 64'h88, '0);
    send(K_CSR, CSR_RW, '0, 5'd7, 12'h7c0, {$urandom, $urandom}, '0);

    while (sent < N_INST) begin
      if ($urandom_range(9) == 0) begin
        inst_valid_i = 1'b0;
        @(negedge clk);
      end
      send_random();
    end
    inst_valid_i = 1'b0;

    for (n = 0; n < 200 && exp_q.size() != 0; n++) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected results went missing at the end of the run.", exp_q.size());
      $display("ERRORS FOUND");
      $fatal(1, "results missing");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+include
src/exu_pkg.sv
src/uop_if.sv
src/op_decoder.sv
src/uop_fifo.sv
src/exu_alu.sv
src/csr_file.sv
src/exec_unit.sv
src/exu_top.sv
sim/tb_exu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# A $fatal in the run gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_exu_top -o tb_exu_top

./obj_dir/tb_exu_top
